// ==== logic/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_WIDTH   32          // integer datapath width
`define FLAG_COUNT  6           // OF SF ZF AF CF PF
`define OP_WIDTH    4

// operation codes, numbered as in the combinational ALU
`define OP_MOV      4'd0
`define OP_ADD      4'd1
`define OP_AND      4'd2
`define OP_NOT      4'd7
`define OP_OR       4'd8
`define OP_SAL      4'd12
`define OP_SAR      4'd13

// operand size codes
`define SIZE_8      3'd1
`define SIZE_16     3'd2
`define SIZE_32     3'd3

// set-flag masks, bit 5 down to 0 is OF SF ZF AF CF PF
`define MASK_ALL    6'b111111
`define MASK_LOGIC  6'b111011   // AF left alone
`define MASK_SHIFT1 6'b111011
`define MASK_SHIFTN 6'b011011   // OF undefined for counts above 1
`define MASK_NONE   6'b000000

// shift count classes, execute to flag stage
`define CNT_ZERO    2'd0
`define CNT_ONE     2'd1
`define CNT_MANY    2'd2

`endif

// ==== logic/alu_pkg.sv ====
`include "alu_defs.svh"

package alu_pkg;

    // operand width after size decode
    typedef enum logic [1:0] {
        w8  = 2'd0,
        w16 = 2'd1,
        w32 = 2'd2   // also used for every shift
    } width_t;

    // one flag per field, first field is the msb
    typedef struct packed {
        logic of;    // bit 5
        logic sf;
        logic zf;
        logic af;
        logic cf;
        logic pf;    // bit 0
    } flag_fields_t;

    // same six bits seen by position (masking) or by name (building)
    typedef union packed {
        logic [`FLAG_COUNT-1:0] bits;
        flag_fields_t           named;
    } flags_u;

endpackage

// ==== logic/alu_operand_stage.sv ====
`include "alu_defs.svh"

module alu_operand_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [`OP_WIDTH-1:0]  alu_op,
    input  logic [2:0]            opsize,
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    output logic                  op_valid,
    output logic [`OP_WIDTH-1:0]  op_code,
    output alu_pkg::width_t       width,
    output logic [`ALU_WIDTH-1:0] opa,
    output logic [`ALU_WIDTH-1:0] opb,
    output logic [4:0]            count
);
    import alu_pkg::*;

    width_t                size_width; // width named by the size code
    width_t                eff_width;  // width the op really works at
    logic                  is_shift;
    logic [`ALU_WIDTH-1:0] size_mask;  // ones up to eff_width

    // size code decode, anything unknown runs at 32 bits
    always_comb begin
        case (opsize)
            `SIZE_8:  size_width = w8;
            `SIZE_16: size_width = w16;
            default:  size_width = w32;
        endcase
    end

    assign is_shift  = (alu_op == `OP_SAL) || (alu_op == `OP_SAR);
    assign eff_width = is_shift ? w32 : size_width; // shifts ignore opsize

    always_comb begin
        case (eff_width)
            w8:      size_mask = 32'h0000_00ff;
            w16:     size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    end

    // valid strobe, only control state is reset
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= in_valid;
        end
    end

    // payload loads only with a live operation
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_code <= alu_op;
            width   <= eff_width;
            opa     <= a & size_mask;   // zero-extend from the width
            opb     <= b & size_mask;
            count   <= b[4:0];          // x86 masks the count to 5 bits
        end
    end

endmodule

// ==== logic/alu_execute_stage.sv ====
`include "alu_defs.svh"

module alu_execute_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  op_valid,
    input  logic [`OP_WIDTH-1:0]  op_code,
    input  alu_pkg::width_t       width,
    input  logic [`ALU_WIDTH-1:0] opa,
    input  logic [`ALU_WIDTH-1:0] opb,
    input  logic [4:0]            count,
    output logic                  ex_valid,
    output logic [`OP_WIDTH-1:0]  ex_code,
    output logic [`ALU_WIDTH-1:0] ex_result,
    output logic                  ex_carry,
    output logic                  ex_overflow,
    output logic                  ex_aux,
    output logic                  ex_sign,
    output logic [1:0]            ex_count_class
);
    import alu_pkg::*;

    logic [`ALU_WIDTH:0]        sum;        // extra bit holds the 32-bit carry
    logic [4:0]                 nib_sum;    // low nibble add for AF
    logic [`ALU_WIDTH:0]        sal_ext;    // {carry, result}
    logic signed [`ALU_WIDTH:0] sar_ext;    // {result, carry}
    logic [`ALU_WIDTH-1:0]      size_mask;
    logic                       add_carry;
    logic                       add_ovf;
    logic [`ALU_WIDTH-1:0]      res_d;
    logic                       carry_d;
    logic                       overflow_d;
    logic                       aux_d;
    logic [1:0]                 class_d;

    // top bit of a value at the given width
    function automatic logic msb(input logic [`ALU_WIDTH-1:0] v, input width_t w);
        case (w)
            w8:      msb = v[7];
            w16:     msb = v[15];
            default: msb = v[31];
        endcase
    endfunction

    assign sum     = {1'b0, opa} + {1'b0, opb};
    assign nib_sum = {1'b0, opa[3:0]} + {1'b0, opb[3:0]};
    assign sal_ext = {1'b0, opa} << count;            // last bit out lands in bit 32
    assign sar_ext = $signed({opa, 1'b0}) >>> count;  // sign fill from opa[31]

    // operands are zero-extended, so the carry sits just above the width
    always_comb begin
        case (width)
            w8: begin
                size_mask = 32'h0000_00ff;
                add_carry = sum[8];
            end
            w16: begin
                size_mask = 32'h0000_ffff;
                add_carry = sum[16];
            end
            default: begin
                size_mask = 32'hffff_ffff;
                add_carry = sum[`ALU_WIDTH];
            end
        endcase
    end

    // signed overflow, like signs in and a different sign out
    assign add_ovf = (msb(opa, width) == msb(opb, width))
                   && (msb(sum[`ALU_WIDTH-1:0], width) != msb(opa, width));

    always_comb begin
        res_d      = '0;                // unknown codes give zero
        carry_d    = 1'b0;
        overflow_d = 1'b0;
        aux_d      = 1'b0;
        case (op_code)
            `OP_MOV: res_d = opb;
            `OP_ADD: begin
                res_d      = sum[`ALU_WIDTH-1:0] & size_mask; // wrap at width
                carry_d    = add_carry;
                overflow_d = add_ovf;
                aux_d      = nib_sum[4];   // carry out of bit 3
            end
            `OP_AND: res_d = opa & opb;
            `OP_OR:  res_d = opa | opb;
            `OP_NOT: res_d = ~opa & size_mask; // upper bits stay clear
            `OP_SAL: begin
                res_d      = sal_ext[`ALU_WIDTH-1:0];
                carry_d    = sal_ext[`ALU_WIDTH];
                overflow_d = sal_ext[`ALU_WIDTH-1] ^ sal_ext[`ALU_WIDTH];
            end
            `OP_SAR: begin
                res_d   = sar_ext[`ALU_WIDTH:1];
                carry_d = sar_ext[0];      // OF stays 0
            end
            default: res_d = '0;
        endcase
    end

    // count class saves the flag stage a second count decode
    always_comb begin
        if (count == 5'd0) begin
            class_d = `CNT_ZERO;
        end else if (count == 5'd1) begin
            class_d = `CNT_ONE;
        end else begin
            class_d = `CNT_MANY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            ex_code        <= op_code;
            ex_result      <= res_d;
            ex_carry       <= carry_d;
            ex_overflow    <= overflow_d;
            ex_aux         <= aux_d;
            ex_sign        <= msb(res_d, width); // shifts arrive as w32
            ex_count_class <= class_d;
        end
    end

endmodule

// ==== logic/alu_flag_stage.sv ====
`include "alu_defs.svh"

module alu_flag_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  logic [`OP_WIDTH-1:0]   ex_code,
    input  logic [`ALU_WIDTH-1:0]  ex_result,
    input  logic                   ex_carry,
    input  logic                   ex_overflow,
    input  logic                   ex_aux,
    input  logic                   ex_sign,
    input  logic [1:0]             ex_count_class,
    output logic                   out_valid,
    output logic [`ALU_WIDTH-1:0]  result,
    output alu_pkg::flags_u        flags,
    output logic [`FLAG_COUNT-1:0] set_flags
);
    import alu_pkg::*;

    flags_u                 flags_d;  // raw flags before masking
    logic [`FLAG_COUNT-1:0] mask_d;
    logic                   zf_d;
    logic                   pf_d;

    assign zf_d = (ex_result == '0);   // result is already cut to width
    assign pf_d = ~^ex_result[7:0];    // even parity, low byte only

    always_comb begin
        flags_d.named.of = ex_overflow;
        flags_d.named.sf = ex_sign;
        flags_d.named.zf = zf_d;
        flags_d.named.af = ex_aux;
        flags_d.named.cf = ex_carry;
        flags_d.named.pf = pf_d;
    end

    // which flags each op writes
    always_comb begin
        case (ex_code)
            `OP_ADD: mask_d = `MASK_ALL;
            `OP_AND,
            `OP_OR:  mask_d = `MASK_LOGIC;
            `OP_SAL,
            `OP_SAR: begin
                case (ex_count_class)
                    `CNT_ONE:  mask_d = `MASK_SHIFT1;
                    `CNT_MANY: mask_d = `MASK_SHIFTN;
                    default:   mask_d = `MASK_NONE; // count 0 leaves flags
                endcase
            end
            default: mask_d = `MASK_NONE;       // MOV, NOT and unknown codes
        endcase
    end

    // set_flags is zero on idle cycles so a flag register never writes then
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            set_flags <= `MASK_NONE;
        end else begin
            out_valid <= ex_valid;
            set_flags <= ex_valid ? mask_d : `MASK_NONE;
        end
    end

    // data outputs hold between valid results
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            result     <= ex_result;
            flags.bits <= flags_d.bits & mask_d;  // unwritten flags read 0
        end
    end

endmodule

// ==== logic/alu_pipe.sv ====
`include "alu_defs.svh"

module alu_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`OP_WIDTH-1:0]   alu_op,
    input  logic [2:0]             opsize,
    input  logic [`ALU_WIDTH-1:0]  a,
    input  logic [`ALU_WIDTH-1:0]  b,
    output logic                   out_valid,
    output logic [`ALU_WIDTH-1:0]  result,
    output alu_pkg::flags_u        flags,
    output logic [`FLAG_COUNT-1:0] set_flags
);
    import alu_pkg::*;

    // operand -> execute
    logic                  op_valid;
    logic [`OP_WIDTH-1:0]  op_code;
    width_t                width;
    logic [`ALU_WIDTH-1:0] opa;
    logic [`ALU_WIDTH-1:0] opb;
    logic [4:0]            count;

    // execute -> flag
    logic                  ex_valid;
    logic [`OP_WIDTH-1:0]  ex_code;
    logic [`ALU_WIDTH-1:0] ex_result;
    logic                  ex_carry;
    logic                  ex_overflow;
    logic                  ex_aux;
    logic                  ex_sign;
    logic [1:0]            ex_count_class;

    alu_operand_stage u_operand (   // stage 1, size decode and extend
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .alu_op   (alu_op),
        .opsize   (opsize),
        .a        (a),
        .b        (b),
        .op_valid (op_valid),
        .op_code  (op_code),
        .width    (width),
        .opa      (opa),
        .opb      (opb),
        .count    (count)
    );

    alu_execute_stage u_execute (   // stage 2, result and raw carries
        .clk            (clk),
        .reset          (reset),
        .op_valid       (op_valid),
        .op_code        (op_code),
        .width          (width),
        .opa            (opa),
        .opb            (opb),
        .count          (count),
        .ex_valid       (ex_valid),
        .ex_code        (ex_code),
        .ex_result      (ex_result),
        .ex_carry       (ex_carry),
        .ex_overflow    (ex_overflow),
        .ex_aux         (ex_aux),
        .ex_sign        (ex_sign),
        .ex_count_class (ex_count_class)
    );

    alu_flag_stage u_flag (         // stage 3, flag word and mask
        .clk            (clk),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_code        (ex_code),
        .ex_result      (ex_result),
        .ex_carry       (ex_carry),
        .ex_overflow    (ex_overflow),
        .ex_aux         (ex_aux),
        .ex_sign        (ex_sign),
        .ex_count_class (ex_count_class),
        .out_valid      (out_valid),
        .result         (result),
        .flags          (flags),
        .set_flags      (set_flags)
    );

endmodule

// ==== dv/alu_pipe_assertions.sv ====
`include "alu_defs.svh"

module alu_pipe_assertions (
    input logic                   clk,
    input logic                   reset,
    input logic                   in_valid,
    input logic                   out_valid,
    input logic [`FLAG_COUNT-1:0] flags,
    input logic [`FLAG_COUNT-1:0] set_flags
);

    // fixed three cycle latency, no bubbles added or lost
    latency_check: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(in_valid, 3))
        else $error("out_valid does not follow in_valid by three cycles");

    // idle cycles never write the flag register
    idle_mask_check: assert property (@(posedge clk) disable iff (reset)
        !out_valid |-> (set_flags == '0))
        else $error("set_flags nonzero while out_valid is low");

    // flags hold stale data when idle, so only check live results
    flag_in_mask_check: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> ((flags & ~set_flags) == '0))
        else $error("flag bit set outside set_flags");

    reset_idle_check: assert property (@(posedge clk)
        $past(reset) |-> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

bind alu_pipe alu_pipe_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .flags     (flags),
    .set_flags (set_flags)
);

// ==== dv/alu_pipe_tb.sv ====
`include "alu_defs.svh"

module alu_pipe_tb;

    localparam int          NUM_TABLE     = 22;
    localparam int          NUM_RANDOM    = 200;
    localparam int          WATCHDOG_TIME = (NUM_TABLE + NUM_RANDOM + 20) * 10;
    localparam logic [31:0] LFSR_SEED     = 32'hb4d1_bc1c;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003; // x^32+x^22+x^2+x+1

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic [`OP_WIDTH-1:0]   alu_op;
    logic [2:0]             opsize;
    logic [`ALU_WIDTH-1:0]  a;
    logic [`ALU_WIDTH-1:0]  b;
    logic                   out_valid;
    logic [`ALU_WIDTH-1:0]  result;
    logic [`FLAG_COUNT-1:0] out_flags;
    logic [`FLAG_COUNT-1:0] set_flags;

    // directed table with one row per operation
    string                  tbl_name  [NUM_TABLE];
    logic [`OP_WIDTH-1:0]   tbl_op    [NUM_TABLE];
    logic [2:0]             tbl_size  [NUM_TABLE];
    logic [`ALU_WIDTH-1:0]  tbl_a     [NUM_TABLE];
    logic [`ALU_WIDTH-1:0]  tbl_b     [NUM_TABLE];
    logic [`ALU_WIDTH-1:0]  tbl_res   [NUM_TABLE];
    logic [`FLAG_COUNT-1:0] tbl_mask  [NUM_TABLE];
    logic [`FLAG_COUNT-1:0] tbl_flags [NUM_TABLE];
    int                     rows = 0;

    // results in flight with the oldest at the front
    string                  exp_name  [$];
    logic [`ALU_WIDTH-1:0]  exp_res   [$];
    logic [`FLAG_COUNT-1:0] exp_mask  [$];
    logic [`FLAG_COUNT-1:0] exp_flags [$];
    int                     exp_cycle [$];   // negedge count when due

    string                  cur_name;
    logic [`ALU_WIDTH-1:0]  cur_res;
    logic [`FLAG_COUNT-1:0] cur_mask;
    logic [`FLAG_COUNT-1:0] cur_flags;
    int                     cur_cycle;

    int                     cycle_count = 0; // rising edges seen
    int                     mismatches  = 0;
    int                     proto_errors = 0;
    logic [31:0]            lfsr;

    alu_pipe dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .alu_op    (alu_op),
        .opsize    (opsize),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .flags     (out_flags),
        .set_flags (set_flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // galois step where bit 0 is the output bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);   // one step per bit
        end
    endtask

    function automatic logic top_bit(input logic [31:0] v, input int w);
        logic [31:0] t;
        t = v >> (w - 1);
        return t[0];
    endfunction

    function automatic logic [`FLAG_COUNT-1:0] shift_mask(input logic [4:0] cnt);
        if (cnt == 5'd0) begin
            return `MASK_NONE;            // flags untouched
        end else if (cnt == 5'd1) begin
            return `MASK_SHIFT1;
        end
        return `MASK_SHIFTN;              // OF undefined
    endfunction

    // x86 behavior at the selected width with flags in OF SF ZF AF CF PF order
    task automatic model_alu(input logic [3:0] op, input logic [2:0] size,
                             input logic [31:0] av, input logic [31:0] bv,
                             output logic [31:0] res, output logic [5:0] mask,
                             output logic [5:0] flg);
        int          w;
        logic [31:0] wmask;
        logic [31:0] x;
        logic [31:0] y;
        logic [32:0] full;
        logic [32:0] tmp;
        logic [4:0]  cnt;
        longint      half;                // 2 to the power w-1
        longint      sx;
        longint      sy;
        logic        of;
        logic        sf;
        logic        zf;
        logic        af;
        logic        cf;
        logic        pf;
        case (size)
            `SIZE_8:  w = 8;
            `SIZE_16: w = 16;
            default:  w = 32;             // unknown size codes run at 32
        endcase
        if (op == `OP_SAL || op == `OP_SAR) begin
            w = 32;
        end
        wmask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        half  = longint'(1) << (w - 1);
        x     = av & wmask;
        y     = bv & wmask;
        cnt   = bv[4:0];
        res   = '0;
        mask  = `MASK_NONE;
        of    = 1'b0;
        af    = 1'b0;
        cf    = 1'b0;
        case (op)
            `OP_MOV: res = y;
            `OP_ADD: begin
                full = {1'b0, x} + {1'b0, y};
                res  = full[31:0] & wmask;
                tmp  = full >> w;         // carry out of the top bit
                cf   = tmp[0];
                // signed overflow means the signed sum leaves the w-bit range
                sx   = top_bit(x, w) ? longint'(x) - 2 * half : longint'(x);
                sy   = top_bit(y, w) ? longint'(y) - 2 * half : longint'(y);
                of   = (sx + sy >= half) || (sx + sy < -half);
                af   = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
                mask = `MASK_ALL;
            end
            `OP_AND: begin
                res  = x & y;
                mask = `MASK_LOGIC;
            end
            `OP_OR: begin
                res  = x | y;
                mask = `MASK_LOGIC;
            end
            `OP_NOT: res = ~x & wmask;
            `OP_SAL: begin
                res = av << cnt;
                if (cnt != 5'd0) begin
                    tmp = {1'b0, av} >> (6'd32 - {1'b0, cnt}); // last bit out
                    cf  = tmp[0];
                    of  = res[31] ^ cf;
                end
                mask = shift_mask(cnt);
            end
            `OP_SAR: begin
                res = $signed(av) >>> cnt;
                if (cnt != 5'd0) begin
                    tmp = {1'b0, av} >> (cnt - 5'd1);
                    cf  = tmp[0];
                end
                mask = shift_mask(cnt);
            end
            default: res = '0;
        endcase
        sf  = top_bit(res, w);
        zf  = (res == 32'd0);
        pf  = ~^res[7:0];
        flg = {of, sf, zf, af, cf, pf} & mask;
    endtask

    task automatic add_row(input string name, input logic [3:0] op, input logic [2:0] size,
                           input logic [31:0] av, input logic [31:0] bv,
                           input logic [31:0] res, input logic [5:0] mask,
                           input logic [5:0] flg);
        tbl_name[rows]  = name;
        tbl_op[rows]    = op;
        tbl_size[rows]  = size;
        tbl_a[rows]     = av;
        tbl_b[rows]     = bv;
        tbl_res[rows]   = res;
        tbl_mask[rows]  = mask;
        tbl_flags[rows] = flg;
        rows++;
    endtask

    task automatic load_table();
        // sized add with flags worked out by hand
        add_row("add8_wrap", `OP_ADD, `SIZE_8, 32'h1234_56ff, 32'h0000_0001,
                32'h0000_0000, `MASK_ALL, 6'b001111);
        add_row("add8_ovf", `OP_ADD, `SIZE_8, 32'h0000_007f, 32'h0000_0001,
                32'h0000_0080, `MASK_ALL, 6'b110100);
        add_row("add16_wrap", `OP_ADD, `SIZE_16, 32'h0000_8000, 32'hffff_8000,
                32'h0000_0000, `MASK_ALL, 6'b101011);
        add_row("add16_pf", `OP_ADD, `SIZE_16, 32'h0000_1234, 32'h0000_0001,
                32'h0000_1235, `MASK_ALL, 6'b000001);
        add_row("add32_carry", `OP_ADD, `SIZE_32, 32'hffff_ffff, 32'h0000_0002,
                32'h0000_0001, `MASK_ALL, 6'b000110);
        add_row("add32_ovf", `OP_ADD, `SIZE_32, 32'h7fff_ffff, 32'h7fff_ffff,
                32'hffff_fffe, `MASK_ALL, 6'b110100);
        add_row("add_size0", `OP_ADD, 3'd0, 32'h8000_0000, 32'h8000_0000,
                32'h0000_0000, `MASK_ALL, 6'b101011);
        // logic ops and mov
        add_row("and8", `OP_AND, `SIZE_8, 32'hffff_fff0, 32'hffff_ff3c,
                32'h0000_0030, `MASK_LOGIC, 6'b000001);
        add_row("and32_zero", `OP_AND, `SIZE_32, 32'haaaa_aaaa, 32'h5555_5555,
                32'h0000_0000, `MASK_LOGIC, 6'b001001);
        add_row("or16_sign", `OP_OR, `SIZE_16, 32'h0000_8000, 32'h0000_0001,
                32'h0000_8001, `MASK_LOGIC, 6'b010000);
        add_row("or8_upper", `OP_OR, `SIZE_8, 32'hff00_0011, 32'h00ff_0022,
                32'h0000_0033, `MASK_LOGIC, 6'b000001);
        add_row("not8", `OP_NOT, `SIZE_8, 32'h1234_560f, 32'h0000_0000,
                32'h0000_00f0, `MASK_NONE, 6'b000000);
        add_row("not32", `OP_NOT, `SIZE_32, 32'h0000_ffff, 32'h0000_0000,
                32'hffff_0000, `MASK_NONE, 6'b000000);
        add_row("mov32", `OP_MOV, `SIZE_32, 32'h0000_0000, 32'hdead_beef,
                32'hdead_beef, `MASK_NONE, 6'b000000);
        add_row("mov8", `OP_MOV, `SIZE_8, 32'hffff_ffff, 32'h1234_5678,
                32'h0000_0078, `MASK_NONE, 6'b000000);
        // shifts ignore the size code
        add_row("sal1", `OP_SAL, `SIZE_32, 32'hc000_0001, 32'h0000_0001,
                32'h8000_0002, `MASK_SHIFT1, 6'b010010);
        add_row("sal1_ovf", `OP_SAL, `SIZE_8, 32'h4000_0000, 32'h0000_0001,
                32'h8000_0000, `MASK_SHIFT1, 6'b110001);
        add_row("sar1", `OP_SAR, `SIZE_32, 32'h8000_0003, 32'h0000_0001,
                32'hc000_0001, `MASK_SHIFT1, 6'b010010);
        add_row("sal4", `OP_SAL, `SIZE_32, 32'h1000_0001, 32'h0000_0004,
                32'h0000_0010, `MASK_SHIFTN, 6'b000010);
        add_row("sar8", `OP_SAR, `SIZE_32, 32'hf000_0080, 32'h0000_0008,
                32'hfff0_0000, `MASK_SHIFTN, 6'b010011);
        add_row("sal0", `OP_SAL, `SIZE_32, 32'h1234_5678, 32'h0000_0000,
                32'h1234_5678, `MASK_NONE, 6'b000000);
        add_row("sal33", `OP_SAL, `SIZE_32, 32'h4000_0000, 32'h0000_0021,
                32'h8000_0000, `MASK_SHIFT1, 6'b110001); // count wraps to 1
    endtask

    task automatic drive_op(input logic [3:0] op, input logic [2:0] size,
                            input logic [31:0] av, input logic [31:0] bv);
        in_valid = 1'b1;
        alu_op   = op;
        opsize   = size;
        a        = av;
        b        = bv;
    endtask

    // sampled at the next rising edge and visible three edges later
    task automatic push_expect(input string name, input logic [31:0] res,
                               input logic [5:0] mask, input logic [5:0] flg);
        exp_name.push_back(name);
        exp_res.push_back(res);
        exp_mask.push_back(mask);
        exp_flags.push_back(flg);
        exp_cycle.push_back(cycle_count + 3);
    endtask

    task automatic pop_expect();
        cur_name  = exp_name.pop_front();
        cur_res   = exp_res.pop_front();
        cur_mask  = exp_mask.pop_front();
        cur_flags = exp_flags.pop_front();
        cur_cycle = exp_cycle.pop_front();
    endtask

    // compare the outputs against the oldest result in flight
    task automatic check_outputs();
        if (out_valid === 1'b1) begin
            if (exp_name.size() == 0) begin
                $display("ERROR: out_valid high with no operation in flight, cycle %0d",
                         cycle_count);
                proto_errors++;
            end else begin
                pop_expect();
                if (cycle_count != cur_cycle) begin
                    $display("MISMATCH %s latency: expected cycle %0d, actual %0d",
                             cur_name, cur_cycle, cycle_count);
                    mismatches++;
                end
                if (result !== cur_res) begin
                    $display("MISMATCH %s result: expected %h, actual %h",
                             cur_name, cur_res, result);
                    mismatches++;
                end
                if (set_flags !== cur_mask) begin
                    $display("MISMATCH %s set_flags: expected %b, actual %b",
                             cur_name, cur_mask, set_flags);
                    mismatches++;
                end
                if (out_flags !== cur_flags) begin
                    $display("MISMATCH %s flags: expected %b, actual %b",
                             cur_name, cur_flags, out_flags);
                    mismatches++;
                end
            end
        end else begin
            if (set_flags !== 6'd0) begin
                $display("ERROR: set_flags is %b while out_valid is low", set_flags);
                proto_errors++;
            end
            if (exp_cycle.size() != 0 && exp_cycle[0] <= cycle_count) begin
                pop_expect();
                $display("ERROR: result for %s did not appear on time", cur_name);
                proto_errors++;
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        logic [31:0]            r;
        logic [31:0]            ra;
        logic [31:0]            rb;
        logic [3:0]             rop;
        logic [2:0]             rsize;
        logic [`ALU_WIDTH-1:0]  mres;
        logic [`FLAG_COUNT-1:0] mmask;
        logic [`FLAG_COUNT-1:0] mflags;
        reset    = 1'b1;
        in_valid = 1'b0;
        alu_op   = '0;
        opsize   = '0;
        a        = '0;
        b        = '0;
        lfsr     = LFSR_SEED;
        load_table();
        repeat (3) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NUM_TABLE; i++) begin   // back to back
            step_cycle();
            drive_op(tbl_op[i], tbl_size[i], tbl_a[i], tbl_b[i]);
            push_expect(tbl_name[i], tbl_res[i], tbl_mask[i], tbl_flags[i]);
        end

        step_cycle();
        in_valid = 1'b0;                // idle gap checked each cycle
        repeat (3) step_cycle();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            step_cycle();
            rand_bits(3, r);
            case (r[2:0])
                3'd0, 3'd6: rop = `OP_ADD;
                3'd1:       rop = `OP_AND;
                3'd2:       rop = `OP_OR;
                3'd3:       rop = `OP_NOT;
                3'd4, 3'd7: rop = `OP_SAL;
                default:    rop = `OP_SAR;
            endcase
            rand_bits(2, r);
            case (r[1:0])
                2'd0:    rsize = `SIZE_8;
                2'd1:    rsize = `SIZE_16;
                2'd2:    rsize = `SIZE_32;
                default: rsize = 3'd0;  // unknown code
            endcase
            rand_bits(32, ra);
            rand_bits(32, rb);
            model_alu(rop, rsize, ra, rb, mres, mmask, mflags);
            drive_op(rop, rsize, ra, rb);
            push_expect($sformatf("rand_%0d", i), mres, mmask, mflags);
        end

        step_cycle();
        in_valid = 1'b0;
        while (exp_name.size() != 0) begin
            step_cycle();
        end
        repeat (2) step_cycle();

        $display("errors: %0d mismatches, %0d protocol", mismatches, proto_errors);
        if (mismatches == 0 && proto_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("ERROR: timeout after %0d time units, results stopped arriving",
                 WATCHDOG_TIME);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/alu_pkg.sv
logic/alu_operand_stage.sv
logic/alu_execute_stage.sv
logic/alu_flag_stage.sv
logic/alu_pipe.sv
dv/alu_pipe_assertions.sv
dv/alu_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipelined ALU

VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= >>> PASS
FAIL_MSG  ?= >>> FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q -F "$(FAIL_MSG)" $(LOG); then echo "sim: failure reported"; exit 1; fi
	@if ! grep -q -F "$(PASS_MSG)" $(LOG); then echo "sim: run did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
